// ==== rtl/vic20_loader_cfg.svh ====
// VIC-20 loader configuration
`ifndef VIC20_LOADER_CFG_SVH
`define VIC20_LOADER_CFG_SVH

// ==================
// Tape buffer
// ==================

// Buffer depth in bytes and matching index width
`define VIC_TAP_DEPTH 256
`define VIC_TAP_AW 8

// Header byte carrying the TAP version in bit 0
`define VIC_TAP_VERSION_OFS 12

// ==================
// PRG placement
// ==================

// Cartridge slot used when the image has no load address
`define VIC_CART_BASE 16'hA000
// Load address stops here so the ROMs above stay intact
`define VIC_CART_LAST 16'hBFFF

// Last step of the BASIC pointer injection sequence
`define VIC_INJECT_LAST 31

`endif

// ==== rtl/loader_pkg.sv ====
// Download and memory write types
package loader_pkg;

    // One beat of the download port
    typedef struct packed {
        logic        download;
        logic [7:0]  index;
        logic        wr;
        logic [24:0] addr;
        logic [7:0]  dout;
    } ioctl_t;

    // Media kind carried by the download index
    typedef enum logic [1:0] {
        MEDIA_NONE,
        MEDIA_ROM,
        MEDIA_PRG,
        MEDIA_TAP
    } media_e;

    // Memory write leaving the loader
    typedef struct packed {
        logic [22:0] addr;
        logic [7:0]  data;
        logic        internal;   // core memory, not external RAM
    } mem_write_t;

    function automatic media_e media_of(input logic [7:0] index);
        case (index)
            8'h00:        return MEDIA_ROM;
            8'h01, 8'h41: return MEDIA_PRG;
            8'h81:        return MEDIA_TAP;
            default:      return MEDIA_NONE;
        endcase
    endfunction

endpackage

// ==== rtl/tape_pkg.sv ====
// Tape buffer and tape byte types
`include "vic20_loader_cfg.svh"

package tape_pkg;

    // Index into the tape buffer
    typedef logic [`VIC_TAP_AW-1:0] tap_addr_t;

    // Byte written into the tape buffer
    typedef struct packed {
        tap_addr_t   addr;
        logic [7:0]  data;
    } tap_write_t;

    // Byte handed to the cassette player
    typedef struct packed {
        logic [7:0]  data;
        logic        version;
    } tape_byte_t;

endpackage

// ==== rtl/download_loader.sv ====
// Download loader
`timescale 1ns/1ps
`include "vic20_loader_cfg.svh"

module download_loader (
    input  logic                   clk_sys_i,
    input  logic                   reset_i,
    input  loader_pkg::ioctl_t     dl_i,
    input  logic                   crt_no_load_addr_i,
    output logic                   mem_we_o,
    output loader_pkg::mem_write_t mem_wr_o,
    output logic                   force_reset_o,
    output logic                   tap_we_o,
    output tape_pkg::tap_write_t   tap_wr_o,
    output logic                   tap_active_o,
    output logic                   tap_version_o
);

    loader_pkg::media_e     media;
    loader_pkg::mem_write_t rom_rec;
    loader_pkg::mem_write_t prg_rec;
    loader_pkg::mem_write_t mem_next;
    logic                   rom_hit;
    logic                   prg_dl;
    logic                   prg_dl_q;
    logic                   prg_wr;
    logic                   prg_data;
    logic [15:0]            prg_ptr;
    logic [15:0]            prg_target;
    logic [15:0]            prg_end;
    logic                   auto_reset;
    logic [4:0]             inject_step;
    logic [4:0]             inject_next;
    logic                   inject_fire;
    logic                   mem_sel;

    // Targets served by core memory instead of external RAM
    function automatic logic prg_internal(input logic [15:0] a);
        return (a < 16'h0400) || (a[15:12] == 4'h1) || (a[15:10] == 6'b100101);
    endfunction

    function automatic logic [15:0] inject_addr(input logic [2:0] slot);
        case (slot)
            3'd0:    return 16'h002D;
            3'd1:    return 16'h002E;
            3'd2:    return 16'h002F;
            3'd3:    return 16'h0030;
            3'd4:    return 16'h0031;
            3'd5:    return 16'h0032;
            3'd6:    return 16'h00AE;
            default: return 16'h00AF;
        endcase
    endfunction

    assign media        = loader_pkg::media_of(dl_i.index);
    assign prg_dl       = dl_i.download && (media == loader_pkg::MEDIA_PRG);
    assign prg_wr       = prg_dl && dl_i.wr;
    assign tap_active_o = dl_i.download && (media == loader_pkg::MEDIA_TAP);

    // ==================
    // Address mapping
    // ==================

    always_comb begin
        rom_hit          = 1'b1;
        rom_rec.data     = dl_i.dout;
        rom_rec.internal = 1'b0;
        case (dl_i.addr[15:13])
            3'b000, 3'b001: rom_rec.addr = 23'(dl_i.addr[13:0]);
            3'b010:         rom_rec.addr = 23'h0E000 + 23'(dl_i.addr[12:0]);
            3'b011:         rom_rec.addr = 23'h1E000 + 23'(dl_i.addr[12:0]);
            3'b100:         rom_rec.addr = 23'h0C000 + 23'(dl_i.addr[12:0]);
            3'b101: begin
                // Character ROM lives inside the core
                rom_rec.addr     = 23'h08000 + 23'(dl_i.addr[11:0]);
                rom_rec.internal = 1'b1;
            end
            default: begin
                rom_rec.addr = '0;
                rom_hit      = 1'b0;
            end
        endcase
    end

    // Header bytes 0 and 1 carry the load address
    assign prg_data   = crt_no_load_addr_i || (dl_i.addr > 25'd1);
    assign prg_target = (crt_no_load_addr_i && dl_i.addr == 25'd0) ? `VIC_CART_BASE : prg_ptr;

    assign prg_rec.addr     = 23'(prg_target);
    assign prg_rec.data     = dl_i.dout;
    assign prg_rec.internal = prg_internal(prg_target);

    // Step counter starts at the falling edge of a PRG download
    always_comb begin
        if (prg_dl_q && !prg_dl) begin
            inject_next = 5'd1;
        end else if (inject_step == 5'(`VIC_INJECT_LAST) || inject_step == 5'd0) begin
            inject_next = 5'd0;
        end else begin
            inject_next = inject_step + 5'd1;
        end
    end

    // Odd steps 1 to 15 write the pointer bytes
    assign inject_fire = inject_next[0] && !inject_next[4];

    always_comb begin
        mem_sel  = 1'b1;
        mem_next = '0;
        if (inject_fire) begin
            mem_next.addr     = 23'(inject_addr(inject_next[3:1]));
            mem_next.data     = inject_next[1] ? prg_end[15:8] : prg_end[7:0];
            mem_next.internal = 1'b1;
        end else if (dl_i.download && dl_i.wr && media == loader_pkg::MEDIA_ROM && rom_hit) begin
            mem_next = rom_rec;
        end else if (prg_wr && prg_data) begin
            mem_next = prg_rec;
        end else begin
            mem_sel = 1'b0;
        end
    end

    // ==================
    // Control state
    // ==================

    always_ff @(posedge clk_sys_i) begin
        if (reset_i) begin
            prg_dl_q      <= 1'b0;
            inject_step   <= 5'd0;
            auto_reset    <= 1'b0;
            mem_we_o      <= 1'b0;
            force_reset_o <= 1'b0;
            tap_we_o      <= 1'b0;
            tap_version_o <= 1'b0;
        end else begin
            prg_dl_q      <= prg_dl;
            inject_step   <= inject_next;
            mem_we_o      <= mem_sel;
            force_reset_o <= 1'b0;
            tap_we_o      <= tap_active_o && dl_i.wr && (dl_i.addr < 25'(`VIC_TAP_DEPTH));
            if (prg_wr && prg_data && prg_target == `VIC_CART_BASE) begin
                auto_reset <= 1'b1;
            end
            if (inject_next == 5'(`VIC_INJECT_LAST)) begin
                force_reset_o <= auto_reset;
                auto_reset    <= 1'b0;
            end
            if (tap_active_o && dl_i.wr && dl_i.addr == 25'(`VIC_TAP_VERSION_OFS)) begin
                tap_version_o <= dl_i.dout[0];
            end
        end
    end

    // Payload and load pointer
    always_ff @(posedge clk_sys_i) begin
        if (mem_sel) begin
            mem_wr_o <= mem_next;
        end
        tap_wr_o.addr <= dl_i.addr[`VIC_TAP_AW-1:0];
        tap_wr_o.data <= dl_i.dout;
        if (prg_wr) begin
            if (!prg_data && dl_i.addr == 25'd0) begin
                prg_ptr[7:0] <= dl_i.dout;
            end else if (!prg_data) begin
                prg_ptr[15:8] <= dl_i.dout;
            end else begin
                prg_ptr <= (prg_target == `VIC_CART_LAST) ? `VIC_CART_LAST : prg_target + 16'd1;
                prg_end <= prg_target + 16'd1;
            end
        end
    end

endmodule

// ==== rtl/tape_buffer.sv ====
// Tape byte buffer
`timescale 1ns/1ps
`include "vic20_loader_cfg.svh"

module tape_buffer (
    input  logic                 clk_sys_i,
    input  logic                 reset_i,
    input  logic                 we_i,
    input  tape_pkg::tap_write_t wr_i,
    input  tape_pkg::tap_addr_t  rd_addr_i,
    output logic [7:0]           rd_data_o,
    output logic [`VIC_TAP_AW:0] fill_o
);

    logic [7:0]           mem [`VIC_TAP_DEPTH];
    logic [`VIC_TAP_AW:0] wr_count;

    // Bytes covered once this write lands
    assign wr_count = {1'b0, wr_i.addr} + 1'b1;

    // Storage with registered read port
    always_ff @(posedge clk_sys_i) begin
        if (we_i) begin
            mem[wr_i.addr] <= wr_i.data;
        end
        rd_data_o <= mem[rd_addr_i];
    end

    // Fill level
    always_ff @(posedge clk_sys_i) begin
        if (reset_i) begin
            fill_o <= '0;
        end else if (we_i) begin
            if (wr_i.addr == '0) begin
                // Index 0 starts a new image
                fill_o <= {{`VIC_TAP_AW{1'b0}}, 1'b1};
            end else if (wr_count > fill_o) begin
                fill_o <= wr_count;
            end
        end
    end

endmodule

// ==== rtl/tape_fetch.sv ====
// Tape byte fetcher
`timescale 1ns/1ps
`include "vic20_loader_cfg.svh"

module tape_fetch (
    input  logic                 clk_sys_i,
    input  logic                 reset_i,
    input  logic                 p2_h_i,
    input  logic                 tap_active_i,
    input  logic                 tap_version_i,
    input  logic [`VIC_TAP_AW:0] fill_i,
    input  logic                 wrfull_i,
    output tape_pkg::tap_addr_t  rd_addr_o,
    input  logic [7:0]           rd_data_i,
    output logic                 tap_wrreq_o,
    output tape_pkg::tape_byte_t tap_o,
    output logic                 tap_reset_o
);

    logic                 p2_q;
    logic                 p2_fall;
    logic                 p2_rise;
    logic                 armed;
    logic [`VIC_TAP_AW:0] play_ptr;

    assign p2_fall   = p2_q && !p2_h_i;
    assign p2_rise   = !p2_q && p2_h_i;
    assign rd_addr_o = play_ptr[`VIC_TAP_AW-1:0];

    // ==================
    // Fetch control
    // ==================

    always_ff @(posedge clk_sys_i) begin
        p2_q <= p2_h_i;
        if (reset_i || tap_active_i) begin
            // Rewind while a new image is loading
            play_ptr    <= '0;
            armed       <= 1'b0;
            tap_wrreq_o <= 1'b0;
            tap_reset_o <= 1'b1;
        end else begin
            tap_reset_o <= 1'b0;
            tap_wrreq_o <= 1'b0;
            // Player full holds off new fetches only
            if (p2_fall && play_ptr < fill_i && !wrfull_i) begin
                armed <= 1'b1;
            end
            if (p2_rise && armed) begin
                tap_wrreq_o <= 1'b1;
                armed       <= 1'b0;
                play_ptr    <= play_ptr + 1'b1;
            end
        end
    end

    // Byte is captured during the low phase
    always_ff @(posedge clk_sys_i) begin
        if (armed && !p2_h_i) begin
            tap_o.data    <= rd_data_i;
            tap_o.version <= tap_version_i;
        end
    end

endmodule

// ==== rtl/vic20_loader_top.sv ====
// VIC-20 media loader top level
`timescale 1ns/1ps
`include "vic20_loader_cfg.svh"

module vic20_loader_top (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  loader_pkg::ioctl_t     dl_i,
    input  logic                   crt_no_load_addr_i,
    input  logic                   p2_h_i,
    input  logic                   tap_wrfull_i,
    output logic                   mem_we_o,
    output loader_pkg::mem_write_t mem_wr_o,
    output logic                   force_reset_o,
    output logic                   tap_wrreq_o,
    output tape_pkg::tape_byte_t   tap_o,
    output logic                   tap_reset_o
);

    logic                 tap_we;
    tape_pkg::tap_write_t tap_wr;
    logic                 tap_active;
    logic                 tap_version;
    logic [`VIC_TAP_AW:0] tap_fill;
    tape_pkg::tap_addr_t  tap_rd_addr;
    logic [7:0]           tap_rd_data;

    // ==================
    // Download side
    // ==================

    download_loader u_loader (
        .clk_sys_i          (clk_sys),
        .reset_i            (reset),
        .dl_i               (dl_i),
        .crt_no_load_addr_i (crt_no_load_addr_i),
        .mem_we_o           (mem_we_o),
        .mem_wr_o           (mem_wr_o),
        .force_reset_o      (force_reset_o),
        .tap_we_o           (tap_we),
        .tap_wr_o           (tap_wr),
        .tap_active_o       (tap_active),
        .tap_version_o      (tap_version)
    );

    tape_buffer u_buffer (
        .clk_sys_i (clk_sys),
        .reset_i   (reset),
        .we_i      (tap_we),
        .wr_i      (tap_wr),
        .rd_addr_i (tap_rd_addr),
        .rd_data_o (tap_rd_data),
        .fill_o    (tap_fill)
    );

    // ==================
    // Player side
    // ==================

    tape_fetch u_fetch (
        .clk_sys_i     (clk_sys),
        .reset_i       (reset),
        .p2_h_i        (p2_h_i),
        .tap_active_i  (tap_active),
        .tap_version_i (tap_version),
        .fill_i        (tap_fill),
        .wrfull_i      (tap_wrfull_i),
        .rd_addr_o     (tap_rd_addr),
        .rd_data_i     (tap_rd_data),
        .tap_wrreq_o   (tap_wrreq_o),
        .tap_o         (tap_o),
        .tap_reset_o   (tap_reset_o)
    );

endmodule

// ==== sim/vic20_loader_properties.sv ====
// Loader strobe assertions
`timescale 1ns/1ps

module vic20_loader_properties (
    input logic               clk_sys,
    input logic               reset,
    input loader_pkg::ioctl_t dl_i,
    input logic               mem_we_o,
    input logic               force_reset_o,
    input logic               tap_wrreq_o
);

    // Strobes are cleared by reset
    a_quiet_in_reset: assert property (@(posedge clk_sys)
        reset |=> !mem_we_o && !force_reset_o && !tap_wrreq_o)
        else $error("strobe active after a reset cycle");

    a_force_reset_pulse: assert property (@(posedge clk_sys) disable iff (reset)
        force_reset_o |=> !force_reset_o)
        else $error("force_reset_o longer than one cycle");

    // Player stays idle while a tape image loads
    a_no_fetch_in_tap_load: assert property (@(posedge clk_sys) disable iff (reset)
        (dl_i.download && dl_i.index == 8'h81) |=> !tap_wrreq_o)
        else $error("tap_wrreq_o during a TAP download");

    // Writes inside a download come from a strobe one cycle before
    a_mem_we_follows_wr: assert property (@(posedge clk_sys) disable iff (reset)
        (mem_we_o && $past(dl_i.download)) |-> $past(dl_i.wr))
        else $error("mem_we_o without a download strobe");

endmodule

bind vic20_loader_top vic20_loader_properties u_props (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .dl_i          (dl_i),
    .mem_we_o      (mem_we_o),
    .force_reset_o (force_reset_o),
    .tap_wrreq_o   (tap_wrreq_o)
);

// ==== sim/tb_vic20_loader.sv ====
// VIC-20 loader testbench
`timescale 1ns/1ps
`include "vic20_loader_cfg.svh"

module tb_vic20_loader;

    localparam logic OP_BYTE = 1'b0;
    localparam logic OP_END  = 1'b1;

    // One table row, either a download byte or the end of a download
    typedef struct packed {
        logic        op;
        logic [7:0]  index;
        logic [24:0] addr;
        logic        no_load;
        logic        rnd;
        logic [7:0]  dout;
        logic        exp_we;
        logic [22:0] exp_addr;
        logic        exp_int;
    } step_t;

    logic                   clk_sys;
    logic                   reset;
    loader_pkg::ioctl_t     dl_i;
    logic                   crt_no_load_addr_i;
    logic                   p2_h_i;
    logic                   tap_wrfull_i;
    logic                   mem_we_o;
    loader_pkg::mem_write_t mem_wr_o;
    logic                   force_reset_o;
    logic                   tap_wrreq_o;
    tape_pkg::tape_byte_t   tap_o;
    logic                   tap_reset_o;

    step_t       steps[$];
    logic [7:0]  tap_bytes[$];
    logic        tap_ver = 1'b0;
    logic [15:0] last_addr = '0;
    logic        cart_hit = 1'b0;
    int          cycles = 0;
    int          limit = 2000;
    int          errors = 0;
    int          played = 0;
    int          phase_cnt = 0;
    int          held;

    vic20_loader_top uut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("*** FAILED ***");
            $fatal(1, "simulation timeout");
        end
    end

    // ====================
    // Checks
    // ====================

    task automatic report_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "check failed");
    endtask

    task automatic check_pulse(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_mem(input string what, input loader_pkg::mem_write_t got,
                             input loader_pkg::mem_write_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s addr %h data %h int %b, expected %h %h %b", what,
                got.addr, got.data, got.internal, exp.addr, exp.data, exp.internal));
        end
    endtask

    task automatic check_tape(input string what, input tape_pkg::tape_byte_t got,
                              input tape_pkg::tape_byte_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s data %h ver %b, expected %h %b", what,
                got.data, got.version, exp.data, exp.version));
        end
    endtask

    // ====================
    // Table
    // ====================

    task automatic add_byte(input logic [7:0] index, input logic no_load, input logic [24:0] addr,
                            input logic exp_we, input logic [22:0] exp_addr, input logic exp_int);
        steps.push_back('{OP_BYTE, index, addr, no_load, 1'b1, 8'h00, exp_we, exp_addr, exp_int});
    endtask

    // Two header bytes, low byte first
    task automatic add_prg_header(input logic [15:0] load);
        steps.push_back('{OP_BYTE, 8'h01, 25'd0, 1'b0, 1'b0, load[7:0], 1'b0, 23'h0, 1'b0});
        steps.push_back('{OP_BYTE, 8'h01, 25'd1, 1'b0, 1'b0, load[15:8], 1'b0, 23'h0, 1'b0});
    endtask

    task automatic add_end(input logic [7:0] index);
        steps.push_back('{OP_END, index, 25'd0, 1'b0, 1'b0, 8'h00, 1'b0, 23'h0, 1'b0});
    endtask

    task automatic build_table();
        // ROM regions, the last two unmapped
        add_byte(8'h00, 1'b0, 25'h0123, 1'b1, 23'h00123, 1'b0);
        add_byte(8'h00, 1'b0, 25'h2456, 1'b1, 23'h02456, 1'b0);
        add_byte(8'h00, 1'b0, 25'h4321, 1'b1, 23'h0E321, 1'b0);
        add_byte(8'h00, 1'b0, 25'h7ABC, 1'b1, 23'h1FABC, 1'b0);
        add_byte(8'h00, 1'b0, 25'h8010, 1'b1, 23'h0C010, 1'b0);
        add_byte(8'h00, 1'b0, 25'hA5F3, 1'b1, 23'h085F3, 1'b1);
        add_byte(8'h00, 1'b0, 25'hC000, 1'b0, 23'h00000, 1'b0);
        add_byte(8'h00, 1'b0, 25'hE001, 1'b0, 23'h00000, 1'b0);
        add_end(8'h00);
        // PRG with header across internal region edges
        add_prg_header(16'h03FF);
        add_byte(8'h01, 1'b0, 25'd2, 1'b1, 23'h003FF, 1'b1);
        add_byte(8'h01, 1'b0, 25'd3, 1'b1, 23'h00400, 1'b0);
        add_end(8'h01);
        add_prg_header(16'h1FFF);
        add_byte(8'h01, 1'b0, 25'd2, 1'b1, 23'h01FFF, 1'b1);
        add_byte(8'h01, 1'b0, 25'd3, 1'b1, 23'h02000, 1'b0);
        add_end(8'h01);
        add_prg_header(16'h97FF);
        add_byte(8'h01, 1'b0, 25'd2, 1'b1, 23'h097FF, 1'b1);
        add_byte(8'h01, 1'b0, 25'd3, 1'b1, 23'h09800, 1'b0);
        add_end(8'h01);
        // Load address saturates at the top of the cartridge slot
        add_prg_header(16'hBFFE);
        add_byte(8'h01, 1'b0, 25'd2, 1'b1, 23'h0BFFE, 1'b0);
        add_byte(8'h01, 1'b0, 25'd3, 1'b1, 23'h0BFFF, 1'b0);
        add_byte(8'h01, 1'b0, 25'd4, 1'b1, 23'h0BFFF, 1'b0);
        add_end(8'h01);
        // Headerless cartridge image
        for (int k = 0; k < 4; k++) begin
            add_byte(8'h41, 1'b1, 25'(k), 1'b1, 23'(`VIC_CART_BASE + k), 1'b0);
        end
        add_end(8'h41);
        // Tape image, one byte past the buffer depth
        for (int k = 0; k < 20; k++) begin
            add_byte(8'h81, 1'b0, 25'(k), 1'b0, 23'h0, 1'b0);
        end
        add_byte(8'h81, 1'b0, 25'd300, 1'b0, 23'h0, 1'b0);
        add_end(8'h81);
    endtask

    // ====================
    // Stimulus
    // ====================

    task automatic apply_byte(input step_t s);
        logic [7:0]             d;
        loader_pkg::mem_write_t exp;
        d = s.rnd ? 8'($urandom) : s.dout;
        // Bus phase keeps running while a tape image loads
        if (s.index == 8'h81) begin
            p2_h_i = ~p2_h_i;
        end
        dl_i = '{download: 1'b1, index: s.index, wr: 1'b1, addr: s.addr, dout: d};
        crt_no_load_addr_i = s.no_load;
        @(negedge clk_sys);
        dl_i.wr = 1'b0;
        check_pulse("mem_we_o", mem_we_o, s.exp_we);
        check_pulse("tap_wrreq_o during a download", tap_wrreq_o, 1'b0);
        if (s.exp_we) begin
            exp = '{addr: s.exp_addr, data: d, internal: s.exp_int};
            check_mem("mem_wr_o", mem_wr_o, exp);
            if (s.index != 8'h00) begin
                last_addr = s.exp_addr[15:0];
                cart_hit  = cart_hit || (s.exp_addr[15:0] == `VIC_CART_BASE);
            end
        end
        if (s.index == 8'h81 && s.addr < `VIC_TAP_DEPTH) begin
            tap_bytes.push_back(d);
            if (s.addr == `VIC_TAP_VERSION_OFS) begin
                tap_ver = d[0];
            end
        end
        @(negedge clk_sys);
    endtask

    // Pointer writes on odd cycles, then the optional reset pulse
    task automatic end_download(input logic [7:0] index);
        loader_pkg::mem_write_t exp;
        logic                   is_prg;
        logic                   slot_hit;
        logic [15:0]            ptr;
        int                     k;
        is_prg = (index == 8'h01) || (index == 8'h41);
        ptr = last_addr + 16'd1;
        dl_i.download = 1'b0;
        for (int c = 1; c <= `VIC_INJECT_LAST + 1; c++) begin
            @(negedge clk_sys);
            slot_hit = is_prg && c[0] && (c <= 15);
            check_pulse("mem_we_o after download", mem_we_o, slot_hit);
            check_pulse("force_reset_o", force_reset_o,
                        is_prg && cart_hit && (c == `VIC_INJECT_LAST));
            if (slot_hit) begin
                k = (c - 1) / 2;
                exp.addr     = (k < 6) ? 23'(32'h2D + k) : 23'(32'hAE + k - 6);
                exp.data     = k[0] ? ptr[15:8] : ptr[7:0];
                exp.internal = 1'b1;
                check_mem("pointer write", mem_wr_o, exp);
            end
        end
        cart_hit = 1'b0;
    endtask

    // Bus phase toggles every three cycles while bytes are collected
    task automatic run_player(input int n);
        tape_pkg::tape_byte_t exp;
        repeat (n) begin
            @(negedge clk_sys);
            if (tap_wrreq_o) begin
                if (played >= tap_bytes.size()) begin
                    report_mismatch("tap_wrreq_o beyond the loaded bytes");
                end else begin
                    exp = '{data: tap_bytes[played], version: tap_ver};
                    check_tape("tap_o", tap_o, exp);
                    played++;
                end
            end
            phase_cnt++;
            if (phase_cnt == 3) begin
                phase_cnt = 0;
                p2_h_i = ~p2_h_i;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h2f2d));
        reset = 1'b1;
        dl_i = '0;
        crt_no_load_addr_i = 1'b0;
        p2_h_i = 1'b0;
        tap_wrfull_i = 1'b0;
        build_table();
        limit = 4 * steps.size() + 2000;
        repeat (8) @(negedge clk_sys);
        check_pulse("tap_reset_o in reset", tap_reset_o, 1'b1);
        reset = 1'b0;
        @(negedge clk_sys);
        check_pulse("tap_reset_o after reset", tap_reset_o, 1'b0);
        foreach (steps[i]) begin
            if (steps[i].op == OP_END) begin
                end_download(steps[i].index);
            end else begin
                apply_byte(steps[i]);
            end
        end
        // Stream part of the tape, then stall with the player full
        while (played < 6) run_player(1);
        run_player(4);
        tap_wrfull_i = 1'b1;
        held = played;
        run_player(60);
        if (played > held + 1) begin
            report_mismatch($sformatf("%0d bytes sent while full", played - held));
        end
        tap_wrfull_i = 1'b0;
        while (played < tap_bytes.size()) run_player(1);
        run_player(60);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/loader_pkg.sv
rtl/tape_pkg.sv
rtl/download_loader.sv
rtl/tape_buffer.sv
rtl/tape_fetch.sv
rtl/vic20_loader_top.sv
sim/vic20_loader_properties.sv
sim/tb_vic20_loader.sv

// ==== Makefile ====
# Verilator flow for the VIC-20 media loader

TOP := tb_vic20_loader

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
